/* Makefile */
# Verilator simulation of the SPWM controller
VERILATOR ?= verilator
TOP       ?= spwm_ctrl_tb
FILELIST  ?= spwm_ctrl_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIMFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/gate_driver.sv */
// Dead-time gate driver
module gate_driver (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [spwm_pkg::N_CHANNELS-1:0] pwm_raw,
    input  logic [spwm_pkg::DT_W-1:0]       dead_time,
    input  logic                            enable,
    output logic [spwm_pkg::N_CHANNELS-1:0] gate_hi,
    output logic [spwm_pkg::N_CHANNELS-1:0] gate_lo
);
    import spwm_pkg::*;

    logic [N_CHANNELS-1:0]           pwm_prev;  // Edge detection
    logic [N_CHANNELS-1:0][DT_W-1:0] dt_cnt;    // Remaining dead-time cycles

    always_ff @(posedge clk) begin
        if (reset) begin
            pwm_prev <= '0;
            dt_cnt   <= '0;
            gate_hi  <= '0;
            gate_lo  <= '0;
        end else begin
            pwm_prev <= pwm_raw;
            for (int i = 0; i < N_CHANNELS; i++) begin
                if (!enable) begin
                    // Bridge off, both switches open
                    gate_hi[i] <= 1'b0;
                    gate_lo[i] <= 1'b0;
                    dt_cnt[i]  <= '0;
                end else if (pwm_raw[i] != pwm_prev[i]) begin
                    // Edge, the conducting side drops now and the other waits
                    gate_hi[i] <= pwm_raw[i] && (dead_time == '0);
                    gate_lo[i] <= !pwm_raw[i] && (dead_time == '0);
                    dt_cnt[i]  <= (dead_time == '0) ? '0 : dead_time - 1'b1;
                end else if (dt_cnt[i] != '0) begin
                    dt_cnt[i] <= dt_cnt[i] - 1'b1;  // Both held low
                end else begin
                    gate_hi[i] <= pwm_raw[i];
                    gate_lo[i] <= ~pwm_raw[i];
                end
            end
        end
    end

endmodule

/* hdl/spwm_channel.sv */
// Single SPWM channel
module spwm_channel (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [spwm_pkg::CARRIER_W-1:0] carrier,
    input  logic [spwm_pkg::PHASE_W-1:0]   phase,
    input  logic [7:0]                     amplitude,
    input  logic [spwm_pkg::PHASE_W-1:0]   phase_offset,
    output logic                           pwm_raw
);
    import spwm_pkg::*;

`include "sine_lut.svh"

    logic [PHASE_W-1:0]   ph_sum;
    logic [1:0]           quadrant;
    logic [PHASE_W-3:0]   lut_idx;
    logic [6:0]           lut_mag;
    logic signed [7:0]    sine;     // -127..127
    logic signed [16:0]   scaled;   // sine * amplitude
    logic signed [16:0]   ref_val;  // 128 + scaled / 256

    assign ph_sum   = phase + phase_offset;  // Wraps over the period
    assign quadrant = ph_sum[PHASE_W-1:PHASE_W-2];

    // Odd quadrants run the table backwards
    assign lut_idx = quadrant[0] ? ~ph_sum[PHASE_W-3:0] : ph_sum[PHASE_W-3:0];
    assign lut_mag = sine_quarter(lut_idx);

    // Second half of the period is negative
    assign sine = quadrant[1] ? -$signed({1'b0, lut_mag}) : $signed({1'b0, lut_mag});

    assign scaled  = sine * $signed({1'b0, amplitude});
    assign ref_val = 17'sd128 + (scaled >>> 8);  // Stays within 1..254

    ////////////////////////////////////////////////////////////////////////////
    // Carrier compare
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            pwm_raw <= 1'b0;
        end else begin
            pwm_raw <= ref_val > $signed({{(17-CARRIER_W){1'b0}}, carrier});
        end
    end

endmodule

/* hdl/spwm_controller.sv */
// SPWM command decoder and timebase
module spwm_controller (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic [7:0]                                              rx_data,
    input  logic                                                    rx_done,
    input  logic                                                    tx_busy,
    input  logic                                                    shoot,
    output logic [7:0]                                              tx_data,
    output logic                                                    start_tx,
    output logic [spwm_pkg::CARRIER_W-1:0]                          carrier,
    output logic [spwm_pkg::PHASE_W-1:0]                            phase,
    output logic [spwm_pkg::N_CHANNELS-1:0][7:0]                    amplitude,
    output logic [spwm_pkg::N_CHANNELS-1:0][spwm_pkg::PHASE_W-1:0]  phase_offset,
    output logic [spwm_pkg::DT_W-1:0]                               dead_time,
    output logic                                                    enable,
    output logic                                                    led_red,
    output logic                                                    led_green
);
    import uart_link_pkg::*;
    import spwm_pkg::*;

    dec_state_t           state;
    cmd_op_t              cmd_op;     // Latched command
    logic [3:0]           cmd_ch;
    logic [7:0]           cmd_data;
    logic [CH_W-1:0]      ch_idx;
    logic                 ch_valid;
    logic [7:0]           reply;
    logic                 rep_ack;
    logic                 rep_nack;
    logic                 nack_flag;  // Last reply was a NACK
    logic [CARRIER_W-1:0] tb_count;
    logic [2:0]           shoot_sync; // Two sync stages plus edge history
    logic                 shoot_rise;

    ////////////////////////////////////////////////////////////////////////////
    // Reply decode
    ////////////////////////////////////////////////////////////////////////////
    assign ch_idx   = cmd_ch[CH_W-1:0];
    assign ch_valid = (cmd_ch < N_CHANNELS);

    always_comb begin
        reply    = REPLY_NACK;
        rep_ack  = 1'b0;
        rep_nack = 1'b1;
        if (ch_valid) begin
            rep_nack = 1'b0;
            case (cmd_op)
                CMD_ENABLE, CMD_DISABLE, CMD_TOGGLE,
                CMD_WR_AMP, CMD_WR_PHASE, CMD_WR_DEADTIME: begin
                    reply   = REPLY_ACK;
                    rep_ack = 1'b1;
                end
                CMD_RD_AMP:   reply = amplitude[ch_idx];
                CMD_RD_PHASE: reply = 8'(phase_offset[ch_idx]);
                default:      rep_nack = 1'b1;  // Unknown opcode
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Command FSM and register file
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= DS_IDLE;
            start_tx     <= 1'b0;
            enable       <= 1'b0;
            nack_flag    <= 1'b0;
            dead_time    <= DT_INIT;
            amplitude    <= '0;
            phase_offset <= '0;
        end else begin
            start_tx <= 1'b0;
            case (state)
                DS_IDLE: begin
                    if (rx_done) begin
                        case (cmd_op_t'(rx_data[7:4]))
                            CMD_WR_AMP, CMD_WR_PHASE, CMD_WR_DEADTIME: state <= DS_WAIT_DATA;
                            default: state <= DS_REPLY;
                        endcase
                    end
                end
                DS_WAIT_DATA: if (rx_done) state <= DS_REPLY;
                default: begin  // DS_REPLY, further bytes are dropped
                    if (!tx_busy) begin
                        start_tx <= 1'b1;
                        state    <= DS_IDLE;
                        if (rep_ack) begin  // Apply together with start_tx
                            nack_flag <= 1'b0;
                            case (cmd_op)
                                CMD_ENABLE:      enable <= 1'b1;
                                CMD_DISABLE:     enable <= 1'b0;
                                CMD_TOGGLE:      enable <= ~enable;
                                CMD_WR_AMP:      amplitude[ch_idx] <= cmd_data;
                                CMD_WR_PHASE:    phase_offset[ch_idx] <= cmd_data[PHASE_W-1:0];
                                CMD_WR_DEADTIME: dead_time <= cmd_data[DT_W-1:0];
                                default: ;
                            endcase
                        end else if (rep_nack) begin
                            nack_flag <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Command and reply payload
    always_ff @(posedge clk) begin
        if (state == DS_IDLE && rx_done) begin
            cmd_op <= cmd_op_t'(rx_data[7:4]);
            cmd_ch <= rx_data[3:0];
        end
        if (state == DS_WAIT_DATA && rx_done) cmd_data <= rx_data;
        if (state == DS_REPLY && !tx_busy)    tx_data  <= reply;
    end

    assign led_green = ~enable;     // Active low
    assign led_red   = ~nack_flag;

    ////////////////////////////////////////////////////////////////////////////
    // Carrier and phase timebase
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) shoot_sync <= '0;
        else       shoot_sync <= {shoot_sync[1:0], shoot};
    end

    assign shoot_rise = shoot_sync[1] & ~shoot_sync[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            tb_count <= '0;
            phase    <= '0;
        end else if (shoot_rise) begin  // Resync with the other boards
            tb_count <= '0;
            phase    <= '0;
        end else begin
            tb_count <= tb_count + 1'b1;
            if (tb_count == '1) phase <= phase + 1'b1;  // End of carrier period
        end
    end

    // Upper half of the count folds back, 0..254 then 254..0
    assign carrier = tb_count[CARRIER_W-1] ? {~tb_count[CARRIER_W-2:0], 1'b0}
                                           : {tb_count[CARRIER_W-2:0], 1'b0};

endmodule

/* hdl/spwm_ctrl_top.sv */
// SPWM controller top level
module spwm_ctrl_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rx,
    input  logic                            shoot,
    output logic                            tx,
    output logic [spwm_pkg::N_CHANNELS-1:0] gate_hi,
    output logic [spwm_pkg::N_CHANNELS-1:0] gate_lo,
    output logic                            led_red,
    output logic                            led_green
);
    import spwm_pkg::*;

    logic [7:0]                         rx_data;
    logic                               rx_done;
    logic [7:0]                         tx_data;
    logic                               start_tx;
    logic                               tx_busy;
    logic [CARRIER_W-1:0]               carrier;
    logic [PHASE_W-1:0]                 phase;
    logic [N_CHANNELS-1:0][7:0]         amplitude;
    logic [N_CHANNELS-1:0][PHASE_W-1:0] phase_offset;
    logic [DT_W-1:0]                    dead_time;
    logic                               enable;
    logic [N_CHANNELS-1:0]              pwm_raw;

    uart_rx u_uart_rx (.clk, .reset, .rx, .rx_data, .rx_done);

    uart_tx u_uart_tx (.clk, .reset, .tx_data, .start_tx, .tx, .tx_busy);

    spwm_controller u_controller (
        .clk, .reset, .rx_data, .rx_done, .tx_busy, .shoot,
        .tx_data, .start_tx, .carrier, .phase, .amplitude, .phase_offset,
        .dead_time, .enable, .led_red, .led_green
    );

    // One modulator per half-bridge, shared timebase
    for (genvar g = 0; g < N_CHANNELS; g++) begin : g_channel
        spwm_channel u_channel (
            .clk, .reset, .carrier, .phase,
            .amplitude    (amplitude[g]),
            .phase_offset (phase_offset[g]),
            .pwm_raw      (pwm_raw[g])
        );
    end

    gate_driver u_gate_driver (.clk, .reset, .pwm_raw, .dead_time, .enable, .gate_hi, .gate_lo);

endmodule

/* hdl/spwm_pkg.sv */
// SPWM modulation definitions
package spwm_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Channel bank
    ////////////////////////////////////////////////////////////////////////////
    localparam int N_CHANNELS = 4;                   // Half-bridges driven
    localparam int CH_W       = $clog2(N_CHANNELS);  // Channel index bits

    ////////////////////////////////////////////////////////////////////////////
    // Timebase
    ////////////////////////////////////////////////////////////////////////////
    localparam int CARRIER_W = 8;   // Triangle carrier, 256 clocks per period
    localparam int PHASE_W   = 6;   // 64 sine steps per fundamental period

    // Dead time in clock cycles
    localparam int DT_W = 4;
    localparam logic [DT_W-1:0] DT_INIT = 4'd2;      // Value after reset

endpackage

/* hdl/uart_link_pkg.sv */
// UART command link definitions
package uart_link_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Serial timing
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [7:0] CLKS_PER_BIT = 8'd16;  // Fixed baud divider

    ////////////////////////////////////////////////////////////////////////////
    // Command byte, upper nibble is the opcode, lower nibble the channel
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        CMD_ENABLE      = 4'd1,
        CMD_DISABLE     = 4'd2,
        CMD_TOGGLE      = 4'd3,
        CMD_WR_AMP      = 4'd4,   // Followed by one data byte
        CMD_WR_PHASE    = 4'd5,   // Followed by one data byte
        CMD_RD_AMP      = 4'd6,
        CMD_RD_PHASE    = 4'd7,
        CMD_WR_DEADTIME = 4'd8    // Followed by one data byte
    } cmd_op_t;

    localparam logic [7:0] REPLY_ACK  = 8'h3C;
    localparam logic [7:0] REPLY_NACK = 8'hC3;

    // Decoder FSM
    typedef enum logic [1:0] {DS_IDLE, DS_WAIT_DATA, DS_REPLY} dec_state_t;

endpackage

/* hdl/uart_rx.sv */
// UART receiver 8N1
module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_done
);
    import uart_link_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state;
    logic [1:0] rx_sync;   // Two-flop synchroniser
    logic [7:0] clk_cnt;   // Clocks within the current bit
    logic [2:0] bit_idx;
    logic [7:0] shift;     // Data bits, LSB first

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync <= 2'b11;  // Line idles high
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync[1]) state <= RX_START;  // Falling edge of start bit
                end
                RX_START: begin
                    // Recheck in the middle of the start bit to reject glitches
                    if (clk_cnt == (CLKS_PER_BIT >> 1) - 1'b1) begin
                        clk_cnt <= '0;
                        state   <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CLKS_PER_BIT - 1'b1) begin  // Mid-bit
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                end
                default: begin  // RX_STOP
                    if (clk_cnt == CLKS_PER_BIT - 1'b1) begin
                        rx_done <= rx_sync[1];  // Frame with low stop bit is dropped
                        state   <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == CLKS_PER_BIT - 1'b1)
            shift <= {rx_sync[1], shift[7:1]};
        if (state == RX_STOP && clk_cnt == CLKS_PER_BIT - 1'b1 && rx_sync[1])
            rx_data <= shift;
    end

endmodule

/* hdl/uart_tx.sv */
// UART transmitter 8N1
module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       start_tx,
    output logic       tx,
    output logic       tx_busy
);
    import uart_link_pkg::*;

    logic [8:0] frame;    // Data bits then stop bit, shifted out LSB first
    logic [7:0] clk_cnt;
    logic [3:0] bit_cnt;  // Bits already on the line

    always_ff @(posedge clk) begin
        if (reset) begin
            tx      <= 1'b1;  // Idle high
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (start_tx) begin
                tx      <= 1'b0;  // Start bit
                tx_busy <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == CLKS_PER_BIT - 1'b1) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;  // Stop bit has ended
                tx      <= 1'b1;
            end else begin
                tx      <= frame[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Shift register
    always_ff @(posedge clk) begin
        if (!tx_busy && start_tx)
            frame <= {1'b1, tx_data};
        else if (tx_busy && clk_cnt == CLKS_PER_BIT - 1'b1)
            frame <= {1'b1, frame[8:1]};
    end

endmodule

/* include/sine_lut.svh */
// Quarter-wave sine table
`ifndef SINE_LUT_SVH
`define SINE_LUT_SVH

// 127 * sin(2*pi*(idx + 0.5)/64), half-step offset keeps the quadrants symmetric
function automatic logic [6:0] sine_quarter(input logic [3:0] idx);
    case (idx)
        4'd0:  return 7'd6;
        4'd1:  return 7'd19;
        4'd2:  return 7'd31;
        4'd3:  return 7'd43;
        4'd4:  return 7'd54;
        4'd5:  return 7'd65;
        4'd6:  return 7'd76;
        4'd7:  return 7'd85;
        4'd8:  return 7'd94;
        4'd9:  return 7'd102;
        4'd10: return 7'd109;
        4'd11: return 7'd115;
        4'd12: return 7'd120;
        4'd13: return 7'd123;
        4'd14: return 7'd126;
        default: return 7'd127;  // Peak
    endcase
endfunction

`endif

/* spwm_ctrl_top.f */
+incdir+include
hdl/uart_link_pkg.sv
hdl/spwm_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/spwm_controller.sv
hdl/spwm_channel.sv
hdl/gate_driver.sv
hdl/spwm_ctrl_top.sv
tests/spwm_ctrl_props.sv
tests/spwm_ctrl_tb.sv

/* tests/spwm_ctrl_props.sv */
// Gate and reset assertions
module spwm_ctrl_props (
    input logic                            clk,
    input logic                            reset,
    input logic                            tx,
    input logic                            enable,
    input logic [spwm_pkg::N_CHANNELS-1:0] gate_hi,
    input logic [spwm_pkg::N_CHANNELS-1:0] gate_lo
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // Failed assertions, read at the end of the run

    // Shoot-through guard, one bridge never has both switches on
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        (gate_hi & gate_lo) == '0)
    else begin
        fail_count++;
        $error("high and low gate on together, hi %b lo %b", gate_hi, gate_lo);
    end

    // Outputs follow enable with the one-cycle driver register
    a_off_when_disabled: assert property (@(posedge clk) disable iff (reset)
        !enable |=> (gate_hi == '0 && gate_lo == '0))
    else begin
        fail_count++;
        $error("gates driven while disabled, hi %b lo %b", gate_hi, gate_lo);
    end

    a_reset_state: assert property (@(posedge clk)
        reset |=> (tx && gate_hi == '0 && gate_lo == '0))
    else begin
        fail_count++;
        $error("tx or gates not at idle after reset");
    end

endmodule

bind spwm_ctrl_top spwm_ctrl_props u_props (
    .clk, .reset, .tx, .enable, .gate_hi, .gate_lo
);

/* tests/spwm_ctrl_tb.sv */
// SPWM controller testbench
module spwm_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import uart_link_pkg::*;
    import spwm_pkg::*;

    localparam int REPLY_TIMEOUT = 4000;  // Clocks allowed before a reply start bit

    logic                  clk;
    logic                  reset;
    logic                  rx;
    logic                  shoot;
    logic                  tx;
    logic [N_CHANNELS-1:0] gate_hi;
    logic [N_CHANNELS-1:0] gate_lo;
    logic                  led_red;
    logic                  led_green;
    int                    checks = 0;
    int                    errors = 0;
    int                    dt_model = 2;        // Shared dead time after reset
    logic                  timed_out = 1'b0;    // No reply seen on tx

    spwm_ctrl_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_dut.u_props.fail_count);
        if (errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // UART driver and monitor
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};  // Start bit first and stop bit last
        for (int b = 0; b < 10; b++) begin
            @(posedge clk);
            rx <= frame[b];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic receive_byte(input string name, output logic [7:0] data);
        int wait_cnt;
        wait_cnt = 0;
        data = '0;
        @(negedge clk);
        while (tx !== 1'b0 && wait_cnt < REPLY_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (tx !== 1'b0) begin
            $display("timeout: no reply start bit on tx in test %s", name);
            errors++;
            timed_out = 1'b1;
        end else begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Middle of start bit
            check_value({name, " start bit"}, 0, tx);
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                data[b] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_value({name, " stop bit"}, 1, tx);
        end
    endtask

    // Sends one command while the monitor waits for the reply
    task automatic run_command(input string name, input int nbytes, input logic [7:0] cmd,
                               input logic [7:0] data, input logic [7:0] reply_exp);
        logic [7:0] reply;
        fork
            begin
                send_byte(cmd);
                if (nbytes == 2) send_byte(data);
            end
            receive_byte(name, reply);
        join
        if (!timed_out) begin
            check_value({name, " reply"}, reply_exp, reply);
            if (reply_exp == REPLY_NACK) check_value({name, " led_red"}, 0, led_red);  // Lit
            else if (reply_exp == REPLY_ACK) check_value({name, " led_red"}, 1, led_red);
            if (cmd[7:4] == 4'h8 && reply_exp == REPLY_ACK) dt_model = data[DT_W-1:0];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Gate measurements
    task automatic check_gates_off(input string name);
        int on_cycles;
        on_cycles = 0;
        for (int c = 0; c < 512; c++) begin
            @(negedge clk);
            if ((gate_hi | gate_lo) != '0) on_cycles++;
        end
        check_value({name, " gate on cycles"}, 0, on_cycles);
        check_value({name, " led_green"}, 1, led_green);  // Off
    endtask

    // Reference 128 against the triangle gives 128 of 256 cycles less the dead time
    task automatic check_duty(input string name);
        int hi_cnt [N_CHANNELS];
        hi_cnt = '{default: 0};
        repeat (512) @(negedge clk);  // Settle
        for (int c = 0; c < 256; c++) begin
            @(negedge clk);
            for (int ch = 0; ch < N_CHANNELS; ch++) hi_cnt[ch] += gate_hi[ch];
        end
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            check_value($sformatf("%s ch%0d high cycles", name, ch), 128 - dt_model,
                        hi_cnt[ch]);
        end
        check_value({name, " led_green"}, 0, led_green);
    endtask

    // A symmetric sine gives equal high and low time over one fundamental period
    task automatic check_sine(input string name);
        int hi_cnt [N_CHANNELS];
        int lo_cnt [N_CHANNELS];
        int diff;
        hi_cnt = '{default: 0};
        lo_cnt = '{default: 0};
        repeat (300) @(posedge clk);
        shoot <= 1'b1;  // Resync while running
        repeat (4) @(posedge clk);
        shoot <= 1'b0;
        repeat (8) @(negedge clk);  // Synchroniser and pipeline
        for (int c = 0; c < 16384; c++) begin
            @(negedge clk);
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                hi_cnt[ch] += gate_hi[ch];
                lo_cnt[ch] += gate_lo[ch];
            end
        end
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            diff = hi_cnt[ch] - lo_cnt[ch];
            if (diff < 0) diff = -diff;
            check_value($sformatf("%s ch%0d hi/lo balance", name, ch), 1,
                        diff <= 64 + 64 * dt_model);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Command sequence from the input file
    initial begin
        int         fd;
        int         fields;
        int         nbytes;
        int         check_kind;
        string      line;
        string      name;
        logic [7:0] cmd;
        logic [7:0] data;
        logic [7:0] reply_exp;
        reset = 1'b1;
        rx    = 1'b1;  // Line idle
        shoot = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);
        fd = $fopen("tests/spwm_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/spwm_input.txt");
            errors++;
            end_run();
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                // Comment lines fail the field count
                fields = $sscanf(line, "%s %d %h %h %h %d", name, nbytes, cmd, data,
                                 reply_exp, check_kind);
                if (fields == 6) begin
                    run_command(name, nbytes, cmd, data, reply_exp);
                    if (!timed_out) begin
                        case (check_kind)
                            1: check_gates_off(name);
                            2: check_duty(name);
                            3: check_sine(name);
                            default: ;
                        endcase
                    end
                end
            end
            $fclose(fd);
            end_run();
        end
    end

endmodule

/* tests/spwm_input.txt */
# name bytes cmd data reply check, bytes and reply in hex
# check kind: 0 none, 1 gates off, 2 dead-time duty, 3 sine balance with shoot
enable        1 10 00 3C 0
wr_amp_ch0    2 40 55 3C 0
wr_amp_ch3    2 43 AA 3C 0
wr_phase_ch1  2 51 2A 3C 0
rd_amp_ch0    1 60 00 55 0
rd_amp_ch3    1 63 00 AA 0
rd_phase_ch1  1 71 00 2A 0
wr_amp_ch4    2 44 77 C3 0
bad_opcode    1 F2 00 C3 0
rd_keep_ch0   1 60 00 55 0
disable       1 20 00 3C 1
toggle_on     1 30 00 3C 0
toggle_off    1 30 00 3C 1
zero_ch0      2 40 00 3C 0
zero_ch3      2 43 00 3C 0
deadtime_5    2 80 05 3C 0
enable_duty   1 10 00 3C 2
full_ch0      2 40 FF 3C 0
full_ch1      2 41 FF 3C 0
full_ch2      2 42 FF 3C 0
full_ch3      2 43 FF 3C 3
